// ==== project.f ====
+incdir+rtl
rtl/tproc_mem_pkg.sv
rtl/mem_regs.sv
rtl/mem_access_fsm.sv
rtl/xfer_counter.sv
rtl/mem_bank.sv
rtl/tproc_mem_top.sv
tests/tb_clk_gen.sv
tests/tb_tproc_mem.sv

// ==== rtl/mem_access_fsm.sv ====
/* Access sequencer for single and burst memory transfers
   Drives counter, memory strobes and the stream handshake */

`timescale 1ns/10ps
`default_nettype none

module mem_access_fsm
   import tproc_mem_pkg::*;
(
   input  wire             s_ps_dma_aclk,
   input  wire             rst_i,
   input  wire mem_cmd_t   cmd_i,
   input  wire dma_beat_t  s_dma_i,
   input  wire             cnt_last_i,
   output logic            cnt_load_o,
   output logic            cnt_adv_o,
   output logic            mem_we_o,
   output logic            mem_re_o,
   output logic            dt_capture_o,
   output logic            m_valid_o,
   output logic            m_last_o,
   output logic            s_dma_ready_o,
   output logic            busy_o,
   output logic            done_o
);

   access_state_e  state_r;
   access_state_e  state_nxt;
   logic           rd_wait_r;    // Single read data on its way back
   logic           m_valid_r;
   logic           m_last_r;

   always_comb begin
      state_nxt    = state_r;
      cnt_load_o   = 1'b0;
      cnt_adv_o    = 1'b0;
      mem_we_o     = 1'b0;
      mem_re_o     = 1'b0;
      dt_capture_o = 1'b0;
      case (state_r)
         ST_IDLE: begin
            if (cmd_i.start && (cmd_i.sel != MEM_NONE)) begin
               cnt_load_o = 1'b1;
               if (cmd_i.single) begin
                  state_nxt = cmd_i.write ? ST_SINGLE_WR : ST_SINGLE_RD;
               end else begin
                  state_nxt = cmd_i.write ? ST_DMA_WR : ST_DMA_RD;
               end
            end
         end
         ST_SINGLE_WR: begin
            mem_we_o  = 1'b1;
            state_nxt = ST_DONE;
         end
         ST_SINGLE_RD: begin
            if (rd_wait_r) begin
               dt_capture_o = 1'b1;
               state_nxt    = ST_DONE;
            end else begin
               mem_re_o = 1'b1;
            end
         end
         ST_DMA_WR: begin
            if (s_dma_i.valid) begin
               mem_we_o = 1'b1;
               if (cnt_last_i) state_nxt = ST_DONE;
               else            cnt_adv_o = 1'b1;
            end
         end
         ST_DMA_RD: begin
            mem_re_o = 1'b1;          // One address per cycle
            if (cnt_last_i) state_nxt = ST_DONE;
            else            cnt_adv_o = 1'b1;
         end
         ST_DONE: begin
            if (!cmd_i.start) state_nxt = ST_IDLE;
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // State and read pipeline

   always_ff @(posedge s_ps_dma_aclk) begin
      if (rst_i) begin
         state_r   <= ST_IDLE;
         rd_wait_r <= 1'b0;
         m_valid_r <= 1'b0;
         m_last_r  <= 1'b0;
      end else begin
         state_r   <= state_nxt;
         rd_wait_r <= (state_r == ST_SINGLE_RD) && !rd_wait_r;
         m_valid_r <= (state_r == ST_DMA_RD);    // Lines up with memory read data
         m_last_r  <= (state_r == ST_DMA_RD) && cnt_last_i;
      end
   end

   assign m_valid_o     = m_valid_r;
   assign m_last_o      = m_last_r;
   assign s_dma_ready_o = (state_r == ST_DMA_WR);
   assign busy_o        = (state_r != ST_IDLE) && (state_r != ST_DONE);
   assign done_o        = (state_r == ST_DONE);

   // Writes belong to a started write command
   a_no_we_idle: assert property (@(posedge s_ps_dma_aclk) disable iff (rst_i)
      mem_we_o |-> (state_r != ST_IDLE) && cmd_i.write)
      else $error("memory write strobe outside a write command");

   // Final beat closes the burst
   a_last_ends: assert property (@(posedge s_ps_dma_aclk) disable iff (rst_i)
      m_last_o |-> m_valid_o ##1 !m_valid_o)
      else $error("stream beat after last");

endmodule

`default_nettype wire

// ==== rtl/mem_bank.sv ====
/* Program, data and waveform memories
   Write goes to the selected memory, read has one cycle latency */

`timescale 1ns/10ps
`default_nettype none
`include "tproc_mem_defs.svh"

module mem_bank
   import tproc_mem_pkg::*;
(
   input  wire                 s_ps_dma_aclk,
   input  wire mem_sel_e       sel_i,
   input  wire [7:0]           addr_i,
   input  wire                 we_i,
   input  wire                 re_i,
   input  wire [`MEM_DW-1:0]   wdata_i,
   output logic [`MEM_DW-1:0]  rdata_o
);

   logic [`MEM_DW-1:0] pmem [2**`PMEM_AW];
   logic [`MEM_DW-1:0] dmem [2**`DMEM_AW];
   logic [`MEM_DW-1:0] wmem [2**`WMEM_AW];
   logic [`MEM_DW-1:0] rdata_r;

   //////////////////////////////////////////////////////////////////////
   // Write ports, one per array

   always_ff @(posedge s_ps_dma_aclk) begin
      if (we_i && (sel_i == MEM_PMEM)) begin
         pmem[addr_i[`PMEM_AW-1:0]] <= wdata_i;
      end
   end

   always_ff @(posedge s_ps_dma_aclk) begin
      if (we_i && (sel_i == MEM_DMEM)) begin
         dmem[addr_i[`DMEM_AW-1:0]] <= wdata_i;   // Upper address bits ignored
      end
   end

   always_ff @(posedge s_ps_dma_aclk) begin
      if (we_i && (sel_i == MEM_WMEM)) begin
         wmem[addr_i[`WMEM_AW-1:0]] <= wdata_i;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Registered read

   always_ff @(posedge s_ps_dma_aclk) begin
      if (re_i) begin
         case (sel_i)
            MEM_PMEM: rdata_r <= pmem[addr_i[`PMEM_AW-1:0]];
            MEM_DMEM: rdata_r <= dmem[addr_i[`DMEM_AW-1:0]];
            MEM_WMEM: rdata_r <= wmem[addr_i[`WMEM_AW-1:0]];
            default : rdata_r <= '0;
         endcase
      end
   end

   assign rdata_o = rdata_r;

endmodule

`default_nettype wire

// ==== rtl/mem_regs.sv ====
/* Host register file
   Configuration, address, length, data in and captured data out */

`timescale 1ns/10ps
`default_nettype none
`include "tproc_mem_defs.svh"

module mem_regs
   import tproc_mem_pkg::*;
(
   input  wire                 s_ps_dma_aclk,
   input  wire                 rst_i,
   input  wire reg_bus_t       reg_bus_i,
   input  wire                 dt_capture_i,
   input  wire [`MEM_DW-1:0]   mem_rdata_i,
   input  wire                 busy_i,
   input  wire                 done_i,
   output mem_cmd_t            cmd_o,
   output logic [7:0]          start_addr_o,
   output logic [15:0]         len_o,
   output logic [`MEM_DW-1:0]  dt_in_o,
   output logic [31:0]         reg_rdata_o
);

   logic [`CFG_SINGLE_BIT:0]  cfg_r;     // Only the decoded bits are kept
   logic [7:0]                addr_r;
   logic [15:0]               len_r;
   logic [`MEM_DW-1:0]        dt_in_r;
   logic [`MEM_DW-1:0]        dt_out_r;

   //////////////////////////////////////////////////////////////////////
   // Register writes and read data capture

   always_ff @(posedge s_ps_dma_aclk) begin
      if (rst_i) begin
         cfg_r    <= '0;
         addr_r   <= '0;
         len_r    <= '0;
         dt_in_r  <= '0;
         dt_out_r <= '0;
      end else begin
         if (reg_bus_i.we) begin
            case (reg_bus_i.addr)
               `REG_TPROC_CFG : cfg_r   <= reg_bus_i.wdata[`CFG_SINGLE_BIT:0];
               `REG_MEM_ADDR  : addr_r  <= reg_bus_i.wdata[7:0];
               `REG_MEM_LEN   : len_r   <= reg_bus_i.wdata[15:0];
               `REG_MEM_DT_I  : dt_in_r <= reg_bus_i.wdata;
               default        : ;
            endcase
         end
         if (dt_capture_i) begin
            dt_out_r <= mem_rdata_i;    // Single read result
         end
      end
   end

   // Config decode
   assign cmd_o.start  = cfg_r[`CFG_START_BIT];
   assign cmd_o.write  = cfg_r[`CFG_WRITE_BIT];
   assign cmd_o.single = cfg_r[`CFG_SINGLE_BIT];
   assign cmd_o.sel    = mem_sel_e'(cfg_r[`CFG_SEL_LSB +: `CFG_SEL_W]);

   assign start_addr_o = addr_r;
   assign len_o        = len_r;
   assign dt_in_o      = dt_in_r;

   //////////////////////////////////////////////////////////////////////
   // Read mux

   always_comb begin
      case (reg_bus_i.addr)
         `REG_TPROC_CFG    : reg_rdata_o = 32'(cfg_r);
         `REG_MEM_ADDR     : reg_rdata_o = 32'(addr_r);
         `REG_MEM_LEN      : reg_rdata_o = 32'(len_r);
         `REG_MEM_DT_I     : reg_rdata_o = dt_in_r;
         `REG_MEM_DT_O     : reg_rdata_o = dt_out_r;
         `REG_TPROC_STATUS : reg_rdata_o = {30'd0, done_i, busy_i};
         default           : reg_rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/tproc_mem_defs.svh ====
/* Memory access block constants
   Register byte addresses, configuration bit fields and memory sizes */

`ifndef TPROC_MEM_DEFS_SVH
`define TPROC_MEM_DEFS_SVH

// Host register map, byte addresses
`define REG_TPROC_CFG     8'd4
`define REG_MEM_ADDR      8'd8
`define REG_MEM_LEN       8'd12
`define REG_MEM_DT_I      8'd16
`define REG_MEM_DT_O      8'd40
`define REG_TPROC_STATUS  8'd56

// Configuration word fields
`define CFG_START_BIT     0
`define CFG_WRITE_BIT     1
`define CFG_SEL_LSB       2
`define CFG_SEL_W         2
`define CFG_SINGLE_BIT    4

// Memory geometry
`define PMEM_AW           8
`define DMEM_AW           4
`define WMEM_AW           4
`define MEM_DW            32

`endif

// ==== rtl/tproc_mem_pkg.sv ====
/* Shared types for the memory access block
   Bus structs, memory select and access state encodings */

`default_nettype none
`include "tproc_mem_defs.svh"

package tproc_mem_pkg;

   // Host register write port, read is combinational on addr
   typedef struct packed {
      logic                we;
      logic [7:0]          addr;
      logic [`MEM_DW-1:0]  wdata;
   } reg_bus_t;

   typedef struct packed {
      logic                valid;
      logic [`MEM_DW-1:0]  data;
   } dma_beat_t;

   typedef struct packed {
      logic                valid;
      logic                last;   // Final beat of a read burst
      logic [`MEM_DW-1:0]  data;
   } dma_out_t;

   typedef enum logic [1:0] {
      MEM_NONE = 2'd0,
      MEM_PMEM = 2'd1,
      MEM_DMEM = 2'd2,
      MEM_WMEM = 2'd3
   } mem_sel_e;

   // Decoded configuration word
   typedef struct packed {
      logic      start;
      logic      write;
      logic      single;
      mem_sel_e  sel;
   } mem_cmd_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SINGLE_WR,
      ST_SINGLE_RD,
      ST_DMA_WR,
      ST_DMA_RD,
      ST_DONE
   } access_state_e;

endpackage

`default_nettype wire

// ==== rtl/tproc_mem_top.sv ====
/* Host memory access block, top level
   Registers, sequencer, counter and memory bank */

`timescale 1ns/10ps
`default_nettype none
`include "tproc_mem_defs.svh"

module tproc_mem_top
   import tproc_mem_pkg::*;
(
   input  wire             s_ps_dma_aclk,
   input  wire             rst_i,
   input  wire reg_bus_t   reg_bus_i,
   output logic [31:0]     reg_rdata_o,
   input  wire dma_beat_t  s_dma_i,
   output logic            s_dma_ready_o,
   output dma_out_t        m_dma_o
);

   mem_cmd_t            cmd;
   logic [7:0]          start_addr;
   logic [15:0]         len;
   logic [`MEM_DW-1:0]  dt_in;
   logic [`MEM_DW-1:0]  mem_wdata;
   logic [`MEM_DW-1:0]  mem_rdata;
   logic [7:0]          cnt_addr;
   logic                cnt_last;
   logic                cnt_load;
   logic                cnt_adv;
   logic                mem_we;
   logic                mem_re;
   logic                dt_capture;
   logic                m_valid;
   logic                m_last;
   logic                busy;
   logic                done;

   mem_regs u_regs (
      .s_ps_dma_aclk (s_ps_dma_aclk),
      .rst_i         (rst_i),
      .reg_bus_i     (reg_bus_i),
      .dt_capture_i  (dt_capture),
      .mem_rdata_i   (mem_rdata),
      .busy_i        (busy),
      .done_i        (done),
      .cmd_o         (cmd),
      .start_addr_o  (start_addr),
      .len_o         (len),
      .dt_in_o       (dt_in),
      .reg_rdata_o   (reg_rdata_o)
   );

   mem_access_fsm u_fsm (
      .s_ps_dma_aclk (s_ps_dma_aclk),
      .rst_i         (rst_i),
      .cmd_i         (cmd),
      .s_dma_i       (s_dma_i),
      .cnt_last_i    (cnt_last),
      .cnt_load_o    (cnt_load),
      .cnt_adv_o     (cnt_adv),
      .mem_we_o      (mem_we),
      .mem_re_o      (mem_re),
      .dt_capture_o  (dt_capture),
      .m_valid_o     (m_valid),
      .m_last_o      (m_last),
      .s_dma_ready_o (s_dma_ready_o),
      .busy_o        (busy),
      .done_o        (done)
   );

   xfer_counter u_cnt (
      .s_ps_dma_aclk (s_ps_dma_aclk),
      .rst_i         (rst_i),
      .load_i        (cnt_load),
      .adv_i         (cnt_adv),
      .sel_i         (cmd.sel),
      .start_addr_i  (start_addr),
      .len_i         (len),
      .addr_o        (cnt_addr),
      .last_o        (cnt_last)
   );

   // Ready is only up in the stream write state
   assign mem_wdata = s_dma_ready_o ? s_dma_i.data : dt_in;

   mem_bank u_mem (
      .s_ps_dma_aclk (s_ps_dma_aclk),
      .sel_i         (cmd.sel),
      .addr_i        (cnt_addr),
      .we_i          (mem_we),
      .re_i          (mem_re),
      .wdata_i       (mem_wdata),
      .rdata_o       (mem_rdata)
   );

   assign m_dma_o = '{valid: m_valid, last: m_last, data: mem_rdata};

endmodule

`default_nettype wire

// ==== rtl/xfer_counter.sv ====
/* Transfer word counter and address generator
   Address wraps at the depth of the selected memory */

`timescale 1ns/10ps
`default_nettype none
`include "tproc_mem_defs.svh"

module xfer_counter
   import tproc_mem_pkg::*;
(
   input  wire            s_ps_dma_aclk,
   input  wire            rst_i,
   input  wire            load_i,
   input  wire            adv_i,
   input  wire mem_sel_e  sel_i,
   input  wire [7:0]      start_addr_i,
   input  wire [15:0]     len_i,
   output logic [7:0]     addr_o,
   output logic           last_o
);

   localparam logic [7:0] PMEM_MASK = 8'((1 << `PMEM_AW) - 1);
   localparam logic [7:0] DMEM_MASK = 8'((1 << `DMEM_AW) - 1);
   localparam logic [7:0] WMEM_MASK = 8'((1 << `WMEM_AW) - 1);

   logic [7:0]   addr_r;
   logic [15:0]  cnt_r;       // Words left after the current one
   logic [7:0]   wrap_mask;

   always_comb begin
      case (sel_i)
         MEM_PMEM: wrap_mask = PMEM_MASK;
         MEM_DMEM: wrap_mask = DMEM_MASK;
         MEM_WMEM: wrap_mask = WMEM_MASK;
         default : wrap_mask = 8'd0;
      endcase
   end

   always_ff @(posedge s_ps_dma_aclk) begin
      if (rst_i) begin
         addr_r <= '0;
         cnt_r  <= '0;
      end else if (load_i) begin
         addr_r <= start_addr_i & wrap_mask;
         cnt_r  <= (len_i == 16'd0) ? 16'd0 : len_i - 16'd1;   // Zero moves one word
      end else if (adv_i) begin
         addr_r <= (addr_r + 8'd1) & wrap_mask;
         cnt_r  <= cnt_r - 16'd1;
      end
   end

   assign addr_o = addr_r;
   assign last_o = (cnt_r == 16'd0);

   a_no_underrun: assert property (@(posedge s_ps_dma_aclk) disable iff (rst_i)
      adv_i |-> (cnt_r != 16'd0))
      else $error("counter advanced past the final word");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory access testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_tproc_mem -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vtb_tproc_mem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed"
exit 1

// ==== tests/tb_clk_gen.sv ====
/* Testbench clock and reset source
   4 ns clock, reset held high for the first 16 cycles */

`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;       // 4 ns period
   end

   initial begin
      rst_o = 1'b1;
      repeat (16) @(posedge clk_o);
      rst_o <= 1'b0;                   // Released on a rising edge
   end

endmodule

`default_nettype wire

// ==== tests/tb_tproc_mem.sv ====
/* Testbench for the host memory access block
   Register and stream stimulus checked against reference memories */

`timescale 1ns/10ps
`default_nettype none
`include "tproc_mem_defs.svh"

module tb_tproc_mem
   import tproc_mem_pkg::*;
();

   localparam int TIMEOUT = 100;          // Cycles allowed per wait

   logic                s_ps_dma_aclk;
   logic                rst;
   reg_bus_t            reg_bus;
   logic [31:0]         reg_rdata;
   dma_beat_t           s_dma;
   logic                s_dma_ready;
   dma_out_t            m_dma;
   logic [`MEM_DW-1:0]  pmem_model [2**`PMEM_AW];
   logic [`MEM_DW-1:0]  dmem_model [2**`DMEM_AW];
   logic [`MEM_DW-1:0]  wmem_model [2**`WMEM_AW];
   logic [`MEM_DW-1:0]  burst_q [$];      // Words of the last stream write
   logic [31:0]         rd;
   integer              seed;
   logic                wr_window;        // Stream write command issued
   logic                rd_window;

   tb_clk_gen u_clk (.clk_o (s_ps_dma_aclk), .rst_o (rst));

   tproc_mem_top uut (
      .s_ps_dma_aclk (s_ps_dma_aclk),
      .rst_i         (rst),
      .reg_bus_i     (reg_bus),
      .reg_rdata_o   (reg_rdata),
      .s_dma_i       (s_dma),
      .s_dma_ready_o (s_dma_ready),
      .m_dma_o       (m_dma)
   );

   //////////////////////////////////////////////////////////////////////
   // Failure reporting

   task automatic abort_run();
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else report_value(name, got, exp);
   endtask

   // Stream handshake rules
   a_ready_in_window: assert property (@(posedge s_ps_dma_aclk) disable iff (rst)
      s_dma_ready |-> wr_window)
      else report_value("s_dma_ready_o", 32'(s_dma_ready), 32'd0);

   a_beat_accepted: assert property (@(posedge s_ps_dma_aclk) disable iff (rst)
      s_dma.valid |-> s_dma_ready)
      else report_value("s_dma_ready_o", 32'(s_dma_ready), 32'd1);

   a_out_in_window: assert property (@(posedge s_ps_dma_aclk) disable iff (rst)
      m_dma.valid |-> rd_window)
      else report_value("m_dma_o.valid", 32'(m_dma.valid), 32'd0);

   a_last_valid: assert property (@(posedge s_ps_dma_aclk) disable iff (rst)
      m_dma.last |-> m_dma.valid)
      else report_value("m_dma_o.valid", 32'(m_dma.valid), 32'd1);

   //////////////////////////////////////////////////////////////////////
   // Reference memories, addresses taken modulo the depth

   task automatic model_store(input mem_sel_e sel, input logic [7:0] addr,
                              input logic [`MEM_DW-1:0] data);
      case (sel)
         MEM_PMEM: pmem_model[addr[`PMEM_AW-1:0]] = data;
         MEM_DMEM: dmem_model[addr[`DMEM_AW-1:0]] = data;
         MEM_WMEM: wmem_model[addr[`WMEM_AW-1:0]] = data;
         default : ;
      endcase
   endtask

   function automatic logic [`MEM_DW-1:0] model_word(input mem_sel_e sel,
                                                     input logic [7:0] addr);
      case (sel)
         MEM_PMEM: return pmem_model[addr[`PMEM_AW-1:0]];
         MEM_DMEM: return dmem_model[addr[`DMEM_AW-1:0]];
         MEM_WMEM: return wmem_model[addr[`WMEM_AW-1:0]];
         default : return '0;
      endcase
   endfunction

   function automatic logic [31:0] cfg_word(input logic start, input logic write,
                                            input logic single, input mem_sel_e sel);
      logic [31:0] w;
      w = '0;
      w[`CFG_START_BIT]           = start;
      w[`CFG_WRITE_BIT]           = write;
      w[`CFG_SINGLE_BIT]          = single;
      w[`CFG_SEL_LSB +: `CFG_SEL_W] = sel;
      return w;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Register bus access

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      @(posedge s_ps_dma_aclk);
      reg_bus <= '{we: 1'b1, addr: addr, wdata: data};
      @(posedge s_ps_dma_aclk);
      reg_bus <= '{we: 1'b0, addr: addr, wdata: '0};
   endtask

   // Read path is combinational, sampled mid cycle
   task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
      @(posedge s_ps_dma_aclk);
      reg_bus <= '{we: 1'b0, addr: addr, wdata: '0};
      @(negedge s_ps_dma_aclk);
      data = reg_rdata;
   endtask

   task automatic wait_status(input logic [1:0] exp, input string what);
      logic [31:0] st;
      int          cycles;
      cycles = 0;
      do begin
         read_reg(`REG_TPROC_STATUS, st);
         cycles++;
      end while (st != 32'(exp) && cycles < TIMEOUT);
      if (st != 32'(exp)) begin
         $display("Timeout at %0t while waiting for status %s", $time, what);
         abort_run();
      end
   endtask

   // Done must hold until start is dropped
   task automatic finish_op(input logic [31:0] cfg);
      logic [31:0] st;
      logic [31:0] cfg_off;
      wait_status(2'b10, "done");
      read_reg(`REG_TPROC_STATUS, st);
      check_value("REG_TPROC_STATUS", st, 32'h2);
      cfg_off = cfg;
      cfg_off[`CFG_START_BIT] = 1'b0;
      write_reg(`REG_TPROC_CFG, cfg_off);
      wait_status(2'b00, "idle");
   endtask

   //////////////////////////////////////////////////////////////////////
   // Single word and stream operations

   task automatic single_write(input mem_sel_e sel, input logic [7:0] addr,
                               input logic [31:0] data);
      logic [31:0] cfg;
      cfg = cfg_word(1'b1, 1'b1, 1'b1, sel);
      model_store(sel, addr, data);
      write_reg(`REG_MEM_ADDR, 32'(addr));
      write_reg(`REG_MEM_DT_I, data);
      write_reg(`REG_TPROC_CFG, cfg);
      finish_op(cfg);
   endtask

   task automatic single_read(input mem_sel_e sel, input logic [7:0] addr,
                              output logic [31:0] data);
      logic [31:0] cfg;
      cfg = cfg_word(1'b1, 1'b0, 1'b1, sel);
      write_reg(`REG_MEM_ADDR, 32'(addr));
      write_reg(`REG_TPROC_CFG, cfg);
      finish_op(cfg);
      read_reg(`REG_MEM_DT_O, data);
      check_value("REG_MEM_DT_O", data, model_word(sel, addr));
   endtask

   task automatic dma_write(input mem_sel_e sel, input logic [7:0] addr, input int n);
      logic [31:0] cfg;
      logic [31:0] word;
      logic [31:0] st;
      int          cycles;
      cfg = cfg_word(1'b1, 1'b1, 1'b0, sel);
      burst_q.delete();
      for (int i = 0; i < n; i++) begin
         word = $random(seed);
         burst_q.push_back(word);
         model_store(sel, 8'(addr + i), word);
      end
      write_reg(`REG_MEM_ADDR, 32'(addr));
      write_reg(`REG_MEM_LEN, 32'(n));
      @(posedge s_ps_dma_aclk);
      wr_window <= 1'b1;
      write_reg(`REG_TPROC_CFG, cfg);
      cycles = 0;
      do begin
         @(negedge s_ps_dma_aclk);
         cycles++;
      end while (!s_dma_ready && cycles < TIMEOUT);
      if (!s_dma_ready) begin
         $display("Timeout at %0t: stream input never became ready", $time);
         abort_run();
      end
      // Waiting for beats counts as busy
      read_reg(`REG_TPROC_STATUS, st);
      check_value("REG_TPROC_STATUS", st, 32'h1);
      for (int i = 0; i < n; i++) begin
         @(posedge s_ps_dma_aclk);
         s_dma <= '{valid: 1'b1, data: burst_q[i]};    // Back to back beats
      end
      @(posedge s_ps_dma_aclk);
      s_dma <= '{valid: 1'b0, data: '0};
      @(negedge s_ps_dma_aclk);
      check_value("s_dma_ready_o", 32'(s_dma_ready), 32'd0);
      finish_op(cfg);
      @(posedge s_ps_dma_aclk);
      wr_window <= 1'b0;
   endtask

   task automatic dma_read_check(input mem_sel_e sel, input logic [7:0] addr,
                                 input int n);
      logic [31:0] cfg;
      int          cycles;
      cfg = cfg_word(1'b1, 1'b0, 1'b0, sel);
      write_reg(`REG_MEM_ADDR, 32'(addr));
      write_reg(`REG_MEM_LEN, 32'(n));
      @(posedge s_ps_dma_aclk);
      rd_window <= 1'b1;
      write_reg(`REG_TPROC_CFG, cfg);
      cycles = 0;
      do begin
         @(negedge s_ps_dma_aclk);
         cycles++;
      end while (!m_dma.valid && cycles < TIMEOUT);
      if (!m_dma.valid) begin
         $display("Timeout at %0t: no beat on the output stream", $time);
         abort_run();
      end
      // One beat per cycle from here
      for (int i = 0; i < n; i++) begin
         check_value("m_dma_o.valid", 32'(m_dma.valid), 32'd1);
         check_value("m_dma_o.data", m_dma.data, model_word(sel, 8'(addr + i)));
         check_value("m_dma_o.last", 32'(m_dma.last), 32'(i == n - 1));
         @(negedge s_ps_dma_aclk);
      end
      check_value("m_dma_o.valid", 32'(m_dma.valid), 32'd0);
      finish_op(cfg);
      @(posedge s_ps_dma_aclk);
      rd_window <= 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      int cycles;
      seed      = 32'h9384_6cc7;
      reg_bus   = '0;
      s_dma     = '0;
      wr_window = 1'b0;
      rd_window = 1'b0;
      cycles    = 0;
      do begin
         @(negedge s_ps_dma_aclk);
         cycles++;
      end while (rst && cycles < TIMEOUT);
      if (rst) begin
         $display("Reset was never released");
         abort_run();
      end

      // Reset state
      read_reg(`REG_TPROC_STATUS, rd);
      check_value("REG_TPROC_STATUS", rd, 32'd0);
      check_value("m_dma_o.valid", 32'(m_dma.valid), 32'd0);
      check_value("s_dma_ready_o", 32'(s_dma_ready), 32'd0);

      // Same address, two memories
      single_write(MEM_DMEM, 8'd5, 32'hA5A5_0001);
      single_write(MEM_WMEM, 8'd5, 32'h5A5A_0002);
      single_read(MEM_DMEM, 8'd5, rd);
      single_read(MEM_WMEM, 8'd5, rd);

      dma_write(MEM_DMEM, 8'd3, 8);
      dma_read_check(MEM_DMEM, 8'd3, 8);

      // PMEM above the DMEM depth, DMEM slot 8 must stay intact
      single_write(MEM_DMEM, 8'd8, 32'h0D0D_0008);
      single_write(MEM_PMEM, 8'd200, $random(seed));
      single_read(MEM_PMEM, 8'd200, rd);
      single_read(MEM_DMEM, 8'd8, rd);

      // Burst across the end of DMEM
      dma_write(MEM_DMEM, 8'd14, 4);
      single_read(MEM_DMEM, 8'd0, rd);
      check_value("REG_MEM_DT_O", rd, burst_q[2]);

      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire
